// ==== Makefile ====
# Verilator build and run of the tile fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_tile_fetch
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run's own exit status is ignored, the log search decides
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
tile_pkg.sv
nest4_counter.sv
tile_addr_gen.sv
sync_ram.sv
tile_fetch_ctrl.sv
tile_fetch_top.sv
tb_tile_fetch.sv

// ==== nest4_counter.sv ====
/*
 * four level nested loop counter
 *   counts park at their bound after reset or syn_rst
 *   first ena loads zero, later ena cycles step c0 and carry outward
 *   done pulses with the last tuple of the nest
 */

`timescale 1ns/100ps

module nest4_counter #(
    parameter int tile_w = 4,
    parameter int tile_h = 3,
    parameter int tile_c = 2,
    parameter int tile_n = 2
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ena,
    input  logic                 syn_rst,
    output tile_pkg::cnt_tuple_t cnt,
    output logic                 done
);

    localparam int bound [4] = '{tile_w, tile_h, tile_c, tile_n};

    tile_pkg::cnt_t cnt_q [4];
    logic [4:0]     carry;      // carry[i] set when levels below i are all full
    logic           last_q;     // outermost full flag, one cycle old

    assign carry[0] = 1'b1;

    genvar i;
    for (i = 0; i < 4; i++) begin : g_lvl
        localparam tile_pkg::cnt_t max_v  = tile_pkg::cnt_t'(bound[i]);
        localparam tile_pkg::cnt_t last_v = tile_pkg::cnt_t'(bound[i] - 1);

        assign carry[i+1] = carry[i] && (cnt_q[i] == last_v);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt_q[i] <= max_v;                 // parked
            end else if (syn_rst) begin
                cnt_q[i] <= max_v;
            end else if (ena) begin
                if (cnt_q[i] == max_v) begin
                    cnt_q[i] <= '0;                // load cycle
                end else if (carry[i]) begin
                    if (cnt_q[i] == last_v) begin
                        cnt_q[i] <= '0;            // roll over
                    end else begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end
            end
        end

        // parked value is the only one allowed past bound-1
        a_cnt_bound: assert property (
            @(posedge clk) disable iff (rst) cnt_q[i] <= max_v
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= 1'b0;
        end else begin
            last_q <= carry[4];
        end
    end

    assign done = carry[4] && !last_q;    // rising edge of outermost full

    assign cnt = '{c3: cnt_q[3], c2: cnt_q[2], c1: cnt_q[1], c0: cnt_q[0]};

endmodule

// ==== sync_ram.sv ====
/*
 * simple dual port RAM
 *   one write port, one read port with a single cycle of latency
 */

`timescale 1ns/100ps

module sync_ram #(
    parameter int data_w = 16,
    parameter int depth  = 256
)(
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [data_w-1:0]        wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [data_w-1:0]        rd_data
);

    logic [data_w-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== tb_tile_fetch.sv ====
/*
 * testbench for the tile fetch engine
 *   clock, reset and source memory load through the host port
 *   four-phase req/ack handshake with random gaps and hold times
 *   tile buffer readback against a reference model of the strides
 *   req to ack latency check, watchdog
 */

`timescale 1ns/100ps

module tb_tile_fetch;

    localparam int tile_w = 4;
    localparam int tile_h = 3;
    localparam int tile_c = 2;
    localparam int tile_n = 2;
    localparam int img_w  = 16;
    localparam int img_h  = 8;
    localparam int img_c  = 4;

    localparam int elements   = tile_w * tile_h * tile_c * tile_n;
    localparam int plane_sz   = img_w * img_h;
    localparam int volume_sz  = plane_sz * img_c;
    localparam int src_depth  = 1 << tile_pkg::src_aw;
    localparam int img_n      = src_depth / volume_sz;    // batches held by the source memory
    localparam int clk_period = 100;
    localparam int drive_dly  = 10;
    localparam int rst_cycles = 16;
    localparam int n_tiles    = 22;
    localparam int unsigned seed = 32'h6d29_be20;
    // reset and full memory load, then gap, fetch, hold and readback per tile
    localparam int timeout_cycles =
        rst_cycles + src_depth + n_tiles * (3 * elements + 40) + 200;

    logic                clk;
    logic                rst;
    logic                req;
    tile_pkg::tile_req_t tile_req;
    tile_pkg::mem_wr_t   load;
    tile_pkg::buf_addr_t buf_rd_addr;
    logic                ack;
    tile_pkg::pixel_t    buf_rd_data;

    tile_pkg::pixel_t    src_model [src_depth];    // copy of the source memory

    logic                rd_req;       // a buffer read was issued this cycle
    int                  rd_idx;
    tile_pkg::src_addr_t rd_base;
    logic                chk_valid = 1'b0;
    int                  chk_idx;
    tile_pkg::src_addr_t chk_base;
    int                  n_checked = 0;

    tile_fetch_top #(
        .tile_w (tile_w),
        .tile_h (tile_h),
        .tile_c (tile_c),
        .tile_n (tile_n),
        .img_w  (img_w),
        .img_h  (img_h),
        .img_c  (img_c)
    ) tile_fetch_top_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .tile_req    (tile_req),
        .load        (load),
        .buf_rd_addr (buf_rd_addr),
        .ack         (ack),
        .buf_rd_data (buf_rd_data)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // expected buffer word idx of the tile at base with column innermost
    function automatic tile_pkg::pixel_t ref_pixel(input tile_pkg::src_addr_t base,
                                                    input int idx);
        int col;
        int row;
        int ch;
        int bat;
        int addr;
        col  = idx % tile_w;
        row  = (idx / tile_w) % tile_h;
        ch   = (idx / (tile_w * tile_h)) % tile_c;
        bat  = idx / (tile_w * tile_h * tile_c);
        addr = int'(base) + col + row * img_w + ch * plane_sz + bat * volume_sz;
        return src_model[tile_pkg::src_addr_t'(addr % src_depth)];
    endfunction

    function automatic tile_pkg::src_addr_t tile_base(input int col, input int row,
                                                       input int ch, input int bat);
        return tile_pkg::src_addr_t'(col + row * img_w + ch * plane_sz + bat * volume_sz);
    endfunction

    // any origin that keeps the whole tile inside the image
    function automatic tile_pkg::src_addr_t random_base();
        int col;
        int row;
        int ch;
        int bat;
        col = $urandom_range(img_w - tile_w, 0);
        row = $urandom_range(img_h - tile_h, 0);
        ch  = $urandom_range(img_c - tile_c, 0);
        bat = $urandom_range(img_n - tile_n, 0);
        return tile_base(col, row, ch, bat);
    endfunction

    // ack must stay low while the engine is idle
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #(drive_dly);
            check_equal("ack", 32'(ack), 32'd0);
        end
    endtask

    task automatic load_source();
        int a;
        for (a = 0; a < src_depth; a++) begin
            src_model[tile_pkg::src_addr_t'(a)] = tile_pkg::pixel_t'($urandom);
            load.en   = 1'b1;
            load.addr = tile_pkg::src_addr_t'(a);
            load.data = src_model[tile_pkg::src_addr_t'(a)];
            @(posedge clk);
            #(drive_dly);
        end
        load = '0;
    endtask

    task automatic fetch_tile(input tile_pkg::src_addr_t base);
        int cycles;
        int hold;
        tile_req.base_addr = base;
        @(posedge clk);
        #(drive_dly);
        req = 1'b1;
        @(posedge clk);                 // first edge that samples req
        #(drive_dly);
        cycles = 0;
        while (ack !== 1'b1 && cycles < elements + 40) begin
            @(posedge clk);
            #(drive_dly);
            cycles++;
        end
        if (ack !== 1'b1) begin
            abort_run($sformatf("ack did not rise within %0d cycles of req", cycles));
        end
        check_equal("req to ack cycles", 32'(cycles), 32'(elements + 5));
        hold = $urandom_range(7, 0);
        repeat (hold) begin
            @(posedge clk);
            #(drive_dly);
            check_equal("ack while req held", 32'(ack), 32'd1);
        end
        req = 1'b0;
        cycles = 0;
        while (ack !== 1'b0 && cycles < 4) begin
            @(posedge clk);
            #(drive_dly);
            cycles++;
        end
        if (ack !== 1'b0) begin
            abort_run("ack did not fall after req was released");
        end
    endtask

    // one address per cycle with the data compared by the checker process
    task automatic read_tile(input tile_pkg::src_addr_t base);
        int i;
        for (i = 0; i < elements; i++) begin
            buf_rd_addr = tile_pkg::buf_addr_t'(i);
            rd_idx      = i;
            rd_base     = base;
            rd_req      = 1'b1;
            @(posedge clk);
            #(drive_dly);
        end
        rd_req = 1'b0;
    endtask

    task automatic run_tile(input tile_pkg::src_addr_t base);
        fetch_tile(base);
        read_tile(base);
    endtask

    always @(posedge clk) begin
        chk_valid <= rd_req;
        chk_idx   <= rd_idx;
        chk_base  <= rd_base;
    end

    // read data is registered at the rising edge and stable by the falling one
    always @(negedge clk) begin
        if (chk_valid) begin
            check_equal($sformatf("buf_rd_data[%0d]", chk_idx), 32'(buf_rd_data),
                        32'(ref_pixel(chk_base, chk_idx)));
            n_checked++;
        end
    end

    initial begin
        #(timeout_cycles * clk_period);
        abort_run("watchdog expired before all tiles were checked");
    end

    initial begin
        int gap;
        void'($urandom(seed));
        rst         = 1'b1;
        req         = 1'b0;
        tile_req    = '0;
        load        = '0;
        buf_rd_addr = '0;
        rd_req      = 1'b0;
        rd_idx      = 0;
        rd_base     = '0;
        repeat (rst_cycles) @(posedge clk);
        #(drive_dly);
        rst = 1'b0;

        idle_cycles(4);
        load_source();
        idle_cycles(2);
        run_tile('0);
        idle_cycles(3);
        run_tile(tile_base(5, 3, 1, 0));    // column, row and channel offset
        repeat (n_tiles - 2) begin
            gap = $urandom_range(7, 0);
            idle_cycles(gap);
            run_tile(random_base());
        end
        idle_cycles(3);

        if (n_checked == n_tiles * elements) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d buffer words were checked",
                                n_checked, n_tiles * elements));
        end
    end

endmodule

// ==== tile_addr_gen.sv ====
/*
 * counter tuple to address conversion, one register stage
 *   source address from base plus strided column, row, channel, batch
 *   dense tile buffer address counting valid tuples from zero
 */

`timescale 1ns/100ps

module tile_addr_gen #(
    parameter int img_w = 16,
    parameter int img_h = 8,
    parameter int img_c = 4
)(
    input  logic                 clk,
    input  logic                 rst,
    input  tile_pkg::cnt_tuple_t cnt,
    input  tile_pkg::tile_req_t  base,
    input  logic                 in_valid,
    output tile_pkg::addr_pair_t addr,
    output logic                 out_valid
);

    localparam int plane_sz  = img_w * img_h;
    localparam int volume_sz = plane_sz * img_c;

    localparam tile_pkg::src_addr_t row_stride    = tile_pkg::src_addr_t'(img_w);
    localparam tile_pkg::src_addr_t plane_stride  = tile_pkg::src_addr_t'(plane_sz);
    localparam tile_pkg::src_addr_t volume_stride = tile_pkg::src_addr_t'(volume_sz);

    tile_pkg::src_addr_t col_off;
    tile_pkg::src_addr_t row_off;
    tile_pkg::src_addr_t ch_off;
    tile_pkg::src_addr_t bat_off;
    tile_pkg::src_addr_t src_next;

    assign col_off = tile_pkg::src_addr_t'(cnt.c0);
    assign row_off = tile_pkg::src_addr_t'(cnt.c1) * row_stride;
    assign ch_off  = tile_pkg::src_addr_t'(cnt.c2) * plane_stride;
    assign bat_off = tile_pkg::src_addr_t'(cnt.c3) * volume_stride;

    assign src_next = base.base_addr + col_off + row_off + ch_off + bat_off;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            addr.src_addr <= src_next;
            // valid tuples of one tile arrive back to back
            if (out_valid) begin
                addr.buf_addr <= addr.buf_addr + 1'b1;
            end else begin
                addr.buf_addr <= '0;               // first tuple of a tile
            end
        end
    end

endmodule

// ==== tile_fetch_ctrl.sv ====
/*
 * tile fetch sequencer
 *   four-phase req/ack handshake with the host
 *   counter start via syn_rst and ena, tuple valid marking
 *   source read issue and delayed tile buffer write, drain before ack
 */

`timescale 1ns/100ps

module tile_fetch_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  tile_pkg::tile_req_t  tile_req,
    input  logic                 done,
    input  tile_pkg::addr_pair_t addr,
    input  logic                 addr_valid,
    output logic                 ack,
    output logic                 ena,
    output logic                 syn_rst,
    output tile_pkg::tile_req_t  base,
    output logic                 cnt_valid,
    output tile_pkg::src_addr_t  src_rd_addr,
    output logic                 buf_we,
    output tile_pkg::buf_addr_t  buf_wr_addr
);

    typedef enum logic [2:0] {
        st_idle,
        st_sync,      // counter parked by syn_rst
        st_run,       // load cycle then one tuple per cycle
        st_drain,     // address, read and write stages empty out
        st_ack
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_idle;
            ack       <= 1'b0;
            ena       <= 1'b0;
            syn_rst   <= 1'b0;
            cnt_valid <= 1'b0;
            buf_we    <= 1'b0;
        end else begin
            buf_we <= addr_valid;                  // lines up with RAM read data
            case (state)
                st_idle: begin
                    if (req) begin
                        syn_rst <= 1'b1;
                        state   <= st_sync;
                    end
                end
                st_sync: begin
                    syn_rst <= 1'b0;
                    ena     <= 1'b1;
                    state   <= st_run;
                end
                st_run: begin
                    cnt_valid <= 1'b1;             // tuples valid after the load cycle
                    if (done) begin
                        ena       <= 1'b0;
                        cnt_valid <= 1'b0;
                        state     <= st_drain;
                    end
                end
                st_drain: begin
                    if (!addr_valid && !buf_we) begin
                        ack   <= 1'b1;
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            base <= tile_req;                      // host holds it stable with req
        end
        buf_wr_addr <= addr.buf_addr;
    end

    assign src_rd_addr = addr.src_addr;

    a_no_we_idle: assert property (
        @(posedge clk) disable iff (rst) state == st_idle |-> !buf_we
    );

    // ack only with the whole tile written and no write pending
    a_ack_drained: assert property (
        @(posedge clk) disable iff (rst) ack |-> !addr_valid && !buf_we
    );

endmodule

// ==== tile_fetch_top.sv ====
/*
 * tile fetch engine top level
 *   nested counter, address generator, sequencer
 *   source memory with host load port, tile buffer with host read port
 */

`timescale 1ns/100ps

module tile_fetch_top #(
    parameter int tile_w = 4,
    parameter int tile_h = 3,
    parameter int tile_c = 2,
    parameter int tile_n = 2,
    parameter int img_w  = 16,
    parameter int img_h  = 8,
    parameter int img_c  = 4
)(
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  tile_pkg::tile_req_t tile_req,
    input  tile_pkg::mem_wr_t   load,
    input  tile_pkg::buf_addr_t buf_rd_addr,
    output logic                ack,
    output tile_pkg::pixel_t    buf_rd_data
);

    logic                 ena;
    logic                 syn_rst;
    logic                 done;
    logic                 cnt_valid;
    logic                 addr_valid;
    logic                 buf_we;
    tile_pkg::cnt_tuple_t cnt;
    tile_pkg::tile_req_t  base;
    tile_pkg::addr_pair_t addr;
    tile_pkg::src_addr_t  src_rd_addr;
    tile_pkg::buf_addr_t  buf_wr_addr;
    tile_pkg::pixel_t     src_rd_data;

    nest4_counter #(
        .tile_w (tile_w),
        .tile_h (tile_h),
        .tile_c (tile_c),
        .tile_n (tile_n)
    ) nest4_counter_i (
        .clk     (clk),
        .rst     (rst),
        .ena     (ena),
        .syn_rst (syn_rst),
        .cnt     (cnt),
        .done    (done)
    );

    tile_addr_gen #(
        .img_w (img_w),
        .img_h (img_h),
        .img_c (img_c)
    ) tile_addr_gen_i (
        .clk       (clk),
        .rst       (rst),
        .cnt       (cnt),
        .base      (base),
        .in_valid  (cnt_valid),
        .addr      (addr),
        .out_valid (addr_valid)
    );

    tile_fetch_ctrl tile_fetch_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .tile_req    (tile_req),
        .done        (done),
        .addr        (addr),
        .addr_valid  (addr_valid),
        .ack         (ack),
        .ena         (ena),
        .syn_rst     (syn_rst),
        .base        (base),
        .cnt_valid   (cnt_valid),
        .src_rd_addr (src_rd_addr),
        .buf_we      (buf_we),
        .buf_wr_addr (buf_wr_addr)
    );

    sync_ram #(
        .data_w (tile_pkg::pixel_w),
        .depth  (1 << tile_pkg::src_aw)
    ) src_mem_i (
        .clk     (clk),
        .we      (load.en),
        .wr_addr (load.addr),
        .wr_data (load.data),
        .rd_addr (src_rd_addr),
        .rd_data (src_rd_data)
    );

    sync_ram #(
        .data_w (tile_pkg::pixel_w),
        .depth  (1 << tile_pkg::buf_aw)
    ) tile_buf_i (
        .clk     (clk),
        .we      (buf_we),
        .wr_addr (buf_wr_addr),
        .wr_data (src_rd_data),    // straight from the source read port
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

endmodule

// ==== tile_pkg.sv ====
/*
 * shared types for the tile fetch engine
 *   pixel word, address and loop counter widths
 *   tile request, source load port, counter tuple, address pair
 */

package tile_pkg;

    localparam int pixel_w = 16;    // feature-map word
    localparam int src_aw  = 12;    // source memory, 4k words
    localparam int buf_aw  = 8;     // tile buffer, 256 words
    localparam int cnt_w   = 8;     // per loop level

    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [src_aw-1:0]  src_addr_t;
    typedef logic [buf_aw-1:0]  buf_addr_t;
    typedef logic [cnt_w-1:0]   cnt_t;

    typedef struct packed {
        src_addr_t base_addr;       // first pixel of the tile
    } tile_req_t;

    // host side write port of the source memory
    typedef struct packed {
        logic      en;
        src_addr_t addr;
        pixel_t    data;
    } mem_wr_t;

    // c0 is the innermost level (column)
    typedef struct packed {
        cnt_t c3;                   // batch
        cnt_t c2;                   // channel
        cnt_t c1;                   // row
        cnt_t c0;                   // column
    } cnt_tuple_t;

    typedef struct packed {
        src_addr_t src_addr;
        buf_addr_t buf_addr;
    } addr_pair_t;

endpackage
